/* design/ecc_mem_pkg.sv */
// Widths are fixed at 32 data bits and 7 check bits; other sizes need a new column table
package ecc_mem_pkg;

  // Word geometry of the protected memory
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned ParityWidth = 7;
  localparam int unsigned CodeWidth   = DataWidth + ParityWidth;
  localparam int unsigned BeWidth     = DataWidth / 8;

  // Bit positions inside err_t
  localparam int unsigned ErrSingleBit = 0;  // Single error seen and corrected
  localparam int unsigned ErrMultiBit  = 1;  // Uncorrectable error

  typedef logic [DataWidth-1:0] data_t;

  // Systematic layout with data in 31:0 and check bits in 38:32
  typedef logic [CodeWidth-1:0] code_t;

  typedef logic [BeWidth-1:0] be_t;

  typedef logic [31:0] bus_addr_t;  // Byte address

  typedef logic [1:0] err_t;

endpackage

/* design/ecc_rmw_ctrl.sv */
// Partial writes withhold gnt_o for one cycle; word index uses addr_i bits above 1 and upper bits alias
`timescale 1ns/10ps

module ecc_rmw_ctrl import ecc_mem_pkg::*; #(
  parameter  int unsigned BankSize      = 256,
  localparam int unsigned BankAddrWidth = $clog2(BankSize)
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     req_i,
  input  logic                     we_i,
  input  bus_addr_t                addr_i,
  input  be_t                      be_i,
  input  data_t                    wdata_i,
  input  data_t                    dec_data_i,
  input  err_t                     dec_err_i,
  output logic                     gnt_o,
  output data_t                    rdata_o,
  output err_t                     err_o,
  output logic                     bank_req_o,
  output logic                     bank_we_o,
  output logic [BankAddrWidth-1:0] bank_addr_o,
  output data_t                    enc_data_o
);

  typedef enum logic {
    NORMAL,
    MERGE_WRITE
  } state_e;

  state_e state_d;
  state_e state_q;

  logic rd_valid_q;  // Accepted read in the last cycle
  logic full_be;
  logic part_wr;

  // Buffered partial write
  logic [BankAddrWidth-1:0] addr_q;
  data_t                    wdata_q;
  be_t                      be_q;

  data_t be_mask;
  data_t merged;

  assign full_be = (be_i == '1);
  assign part_wr = req_i && we_i && !full_be;

  // Expand byte enables to a bit mask
  always_comb begin
    for (int unsigned b = 0; b < BeWidth; b++) begin
      be_mask[8*b +: 8] = {8{be_q[b]}};
    end
  end

  // New bytes over the decoded old word
  assign merged = (be_mask & wdata_q) | (~be_mask & dec_data_i);

  always_comb begin
    state_d     = state_q;
    gnt_o       = 1'b1;
    bank_req_o  = req_i;
    bank_we_o   = we_i && full_be;  // A partial write starts as a read
    bank_addr_o = addr_i[BankAddrWidth+1:2];
    enc_data_o  = wdata_i;
    unique case (state_q)
      NORMAL: begin
        if (part_wr) begin
          state_d = MERGE_WRITE;
        end
      end
      MERGE_WRITE: begin
        gnt_o       = 1'b0;
        bank_req_o  = 1'b1;
        bank_we_o   = 1'b1;
        bank_addr_o = addr_q;
        enc_data_o  = merged;
        state_d     = NORMAL;
      end
      default: begin
        state_d = NORMAL;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= NORMAL;
      rd_valid_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      rd_valid_q <= req_i && gnt_o && !we_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == NORMAL) && part_wr) begin
      addr_q  <= addr_i[BankAddrWidth+1:2];
      wdata_q <= wdata_i;
      be_q    <= be_i;
    end
  end

  assign rdata_o = dec_data_i;
  assign err_o   = rd_valid_q ? dec_err_i : '0;  // Flags only for the read response

  // Grant drops for exactly the merge cycle and then returns
  a_rmw_stall : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && gnt_o && we_i && (be_i != '1) |=> !gnt_o ##1 gnt_o)
    else $error("Partial write did not hold the grant low for one cycle");

endmodule

/* design/ecc_scrubber.sv */
// One scrub step per trigger; triggers that arrive while a step is pending merge into it
`timescale 1ns/10ps

module ecc_scrubber import ecc_mem_pkg::*; #(
  parameter  int unsigned BankSize      = 256,
  localparam int unsigned BankAddrWidth = $clog2(BankSize)
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     scrub_trigger_i,
  input  logic                     intc_req_i,
  input  logic                     intc_we_i,
  input  logic [BankAddrWidth-1:0] intc_addr_i,
  input  code_t                    intc_wdata_i,
  input  code_t                    bank_rdata_i,
  output logic                     bank_req_o,
  output logic                     bank_we_o,
  output logic [BankAddrWidth-1:0] bank_addr_o,
  output code_t                    bank_wdata_o,
  output logic                     scrub_fix_o,
  output logic                     scrub_uncorrectable_o
);

  typedef enum logic [1:0] {
    IDLE,
    READ,
    CHECK,
    FIX
  } state_e;

  state_e state_d;
  state_e state_q;

  logic                     pending_q;
  logic [BankAddrWidth-1:0] scrub_addr_q;

  data_t chk_data;
  err_t  chk_err;
  data_t fix_data_q;  // Corrected word awaiting write back
  code_t fix_code;

  logic scrub_rd;
  logic scrub_wr;
  logic bus_hit;
  logic step_done;

  secded_dec u_dec (
    .code_i (bank_rdata_i),
    .data_o (chk_data),
    .err_o  (chk_err)
  );

  secded_enc u_enc (
    .data_i (fix_data_q),
    .code_o (fix_code)
  );

  // Bus write to the word under scrub makes the fix stale
  assign bus_hit = intc_req_i && intc_we_i && (intc_addr_i == scrub_addr_q);

  always_comb begin
    state_d   = state_q;
    scrub_rd  = 1'b0;
    scrub_wr  = 1'b0;
    step_done = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (pending_q) begin
          state_d = READ;
        end
      end
      READ: begin
        if (!intc_req_i) begin
          scrub_rd = 1'b1;
          state_d  = CHECK;
        end
      end
      CHECK: begin
        if (chk_err[ErrSingleBit] && !bus_hit) begin
          state_d = FIX;
        end else begin
          step_done = 1'b1;  // Clean word or uncorrectable
          state_d   = IDLE;
        end
      end
      FIX: begin
        if (!intc_req_i) begin
          scrub_wr  = 1'b1;
          step_done = 1'b1;
          state_d   = IDLE;
        end else if (bus_hit) begin
          step_done = 1'b1;
          state_d   = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // Bus always wins the bank
  always_comb begin
    if (intc_req_i) begin
      bank_req_o   = 1'b1;
      bank_we_o    = intc_we_i;
      bank_addr_o  = intc_addr_i;
      bank_wdata_o = intc_wdata_i;
    end else begin
      bank_req_o   = scrub_rd || scrub_wr;
      bank_we_o    = scrub_wr;
      bank_addr_o  = scrub_addr_q;
      bank_wdata_o = fix_code;
    end
  end

  assign scrub_fix_o           = scrub_wr;
  assign scrub_uncorrectable_o = (state_q == CHECK) && chk_err[ErrMultiBit];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      pending_q    <= 1'b0;
      scrub_addr_q <= '0;
    end else begin
      state_q   <= state_d;
      pending_q <= scrub_trigger_i || (pending_q && (state_q != IDLE));
      if (step_done) begin
        scrub_addr_q <= scrub_addr_q + 1'b1;  // Wraps since BankSize is a power of two
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == CHECK) begin
      fix_data_q <= chk_data;
    end
  end

  // No scrub read or fix while the bus holds the bank
  a_bus_priority : assert property (@(posedge clk_i) disable iff (!rst_ni)
    intc_req_i |-> !(scrub_rd || scrub_wr))
    else $error("Scrubber requested the bank while the bus held it");

endmodule

/* design/ecc_sram_top.sv */
// BankSize must be a power of two; test_write_mask_ni must stay all zeros outside test
`timescale 1ns/10ps

module ecc_sram_top import ecc_mem_pkg::*; #(
  parameter int unsigned BankSize = 256
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      req_i,
  input  logic      we_i,
  input  bus_addr_t addr_i,
  input  be_t       be_i,
  input  data_t     wdata_i,
  input  logic      scrub_trigger_i,
  input  code_t     test_write_mask_ni,
  output logic      gnt_o,
  output data_t     rdata_o,
  output err_t      err_o,
  output logic      scrub_fix_o,
  output logic      scrub_uncorrectable_o
);

  localparam int unsigned BankAddrWidth = $clog2(BankSize);

  // Controller side of the bank port
  logic                     bank_req;
  logic                     bank_we;
  logic [BankAddrWidth-1:0] bank_addr;
  data_t                    enc_data;
  code_t                    bank_wdata;

  data_t dec_data;
  err_t  dec_err;

  // After arbitration
  logic                     sram_req;
  logic                     sram_we;
  logic [BankAddrWidth-1:0] sram_addr;
  code_t                    sram_wdata;
  code_t                    sram_rdata;

  ecc_rmw_ctrl #(
    .BankSize (BankSize)
  ) u_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .be_i        (be_i),
    .wdata_i     (wdata_i),
    .dec_data_i  (dec_data),
    .dec_err_i   (dec_err),
    .gnt_o       (gnt_o),
    .rdata_o     (rdata_o),
    .err_o       (err_o),
    .bank_req_o  (bank_req),
    .bank_we_o   (bank_we),
    .bank_addr_o (bank_addr),
    .enc_data_o  (enc_data)
  );

  secded_enc u_enc (
    .data_i (enc_data),
    .code_o (bank_wdata)
  );

  secded_dec u_dec (
    .code_i (sram_rdata),
    .data_o (dec_data),
    .err_o  (dec_err)
  );

  ecc_scrubber #(
    .BankSize (BankSize)
  ) u_scrubber (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .scrub_trigger_i       (scrub_trigger_i),
    .intc_req_i            (bank_req),
    .intc_we_i             (bank_we),
    .intc_addr_i           (bank_addr),
    .intc_wdata_i          (bank_wdata),
    .bank_rdata_i          (sram_rdata),
    .bank_req_o            (sram_req),
    .bank_we_o             (sram_we),
    .bank_addr_o           (sram_addr),
    .bank_wdata_o          (sram_wdata),
    .scrub_fix_o           (scrub_fix_o),
    .scrub_uncorrectable_o (scrub_uncorrectable_o)
  );

  sram_bank #(
    .BankSize (BankSize)
  ) u_bank (
    .clk_i    (clk_i),
    .req_i    (sram_req),
    .we_i     (sram_we),
    .addr_i   (sram_addr),
    .wdata_i  (sram_wdata),
    .bit_en_i (~test_write_mask_ni),  // Set mask bits block the write
    .rdata_o  (sram_rdata)
  );

endmodule

/* design/secded_dec.sv */
// Corrects any single-bit error and flags double errors; three or more flipped bits may go unseen
`timescale 1ns/10ps

module secded_dec import ecc_mem_pkg::*; (
  input  code_t code_i,
  output data_t data_o,
  output err_t  err_o
);

  // Syndrome produced by a flip of each data bit
  // Must stay the transpose of the encoder rows
  localparam logic [ParityWidth-1:0] SynTable [DataWidth] = '{
    7'h07, 7'h0B, 7'h13, 7'h23, 7'h43, 7'h0D, 7'h15, 7'h25,
    7'h45, 7'h19, 7'h29, 7'h49, 7'h31, 7'h51, 7'h61, 7'h0E,
    7'h16, 7'h26, 7'h46, 7'h1A, 7'h2A, 7'h4A, 7'h32, 7'h52,
    7'h62, 7'h1C, 7'h2C, 7'h4C, 7'h34, 7'h54, 7'h64, 7'h38
  };

  logic [ParityWidth-1:0] syndrome;
  data_t                  flip;
  logic                   parity_hit;
  logic                   single;

  // Recompute check bits from the stored data and compare
  always_comb begin
    syndrome = code_i[CodeWidth-1:DataWidth];
    for (int unsigned i = 0; i < DataWidth; i++) begin
      if (code_i[i]) begin
        syndrome = syndrome ^ SynTable[i];
      end
    end
  end

  always_comb begin
    for (int unsigned i = 0; i < DataWidth; i++) begin
      flip[i] = (syndrome == SynTable[i]);
    end
  end

  assign parity_hit = $onehot(syndrome);  // Error sits in a check bit
  assign single     = (|flip) || parity_hit;

  assign data_o = code_i[DataWidth-1:0] ^ flip;

  always_comb begin
    err_o               = '0;
    err_o[ErrSingleBit] = single;
    // Even weight or an unused odd pattern cannot be corrected
    err_o[ErrMultiBit]  = (syndrome != '0) && !single;
  end

endmodule

/* design/secded_enc.sv */
// Purely combinational; zero data encodes to an all-zero codeword
`timescale 1ns/10ps

module secded_enc import ecc_mem_pkg::*; (
  input  data_t data_i,
  output code_t code_o
);

  // Data bits feeding each check bit
  // Every data column has weight three and no two columns are equal
  localparam data_t RowMask [ParityWidth] = '{
    32'h0000_7FFF,
    32'h01FF_801F,
    32'h7E07_81E1,
    32'h8E38_8E22,
    32'hB2C9_3244,
    32'hD552_5488,
    32'h69A4_6910
  };

  logic [ParityWidth-1:0] parity;

  always_comb begin
    for (int unsigned j = 0; j < ParityWidth; j++) begin
      parity[j] = ^(data_i & RowMask[j]);  // XOR tree per check bit
    end
  end

  assign code_o = {parity, data_i};

endmodule

/* design/sram_bank.sv */
// Contents come up undefined after power on; rdata_o keeps its value across writes
`timescale 1ns/10ps

module sram_bank import ecc_mem_pkg::*; #(
  parameter  int unsigned BankSize      = 256,
  localparam int unsigned BankAddrWidth = $clog2(BankSize)
) (
  input  logic                     clk_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [BankAddrWidth-1:0] addr_i,
  input  code_t                    wdata_i,
  input  code_t                    bit_en_i,
  output code_t                    rdata_o
);

  code_t mem_q [BankSize];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // Disabled bits keep their stored value
        mem_q[addr_i] <= (wdata_i & bit_en_i) | (mem_q[addr_i] & ~bit_en_i);
      end else begin
        rdata_o <= mem_q[addr_i];  // One cycle read latency
      end
    end
  end

endmodule

/* ecc_sram_top.f */
design/ecc_mem_pkg.sv
design/secded_enc.sv
design/secded_dec.sv
design/sram_bank.sv
design/ecc_rmw_ctrl.sv
design/ecc_scrubber.sv
design/ecc_sram_top.sv
verification/ecc_sram_tb.sv

/* verification/ecc_sram_tb.sv */
// Runs with BankSize 16; every address is written before it is read, and scrub steps use fixed idle gaps
`timescale 1ns/10ps

module ecc_sram_tb import ecc_mem_pkg::*; ();

  localparam int unsigned BankSize    = 16;
  localparam int unsigned ResetCycles = 4;
  localparam int unsigned HalfPeriod  = 50;
  localparam int unsigned DriveDelay  = 10;
  localparam int unsigned BurstLen    = 32;
  localparam int unsigned TrigEvery   = 4;  // Trigger spacing inside the read burst
  localparam int unsigned StepGap     = 6;  // Cycles per scrub step with the bus idle

  // One table row, a bus read or a bus write
  typedef struct packed {
    logic        is_write;
    logic [31:0] addr;       // Word index
    data_t       data;
    be_t         be;
    code_t       mask;
    data_t       exp_data;
    err_t        exp_err;
  } row_t;

  logic      clk;
  logic      rst_n;
  logic      req;
  logic      we;
  bus_addr_t addr;
  be_t       be;
  data_t     wdata;
  logic      scrub_trigger;
  code_t     write_mask;
  logic      gnt;
  data_t     rdata;
  err_t      err;
  logic      scrub_fix;
  logic      scrub_uncorrectable;

  row_t        rows[$];
  data_t       model [BankSize];  // Expected word per address
  logic [15:0] lfsr;
  int unsigned cycles;
  int unsigned cycle_limit;
  int unsigned errors;
  int unsigned tests_passed;
  int unsigned tests_failed;
  int unsigned fix_count;
  int unsigned uncorr_count;

  ecc_sram_top #(
    .BankSize (BankSize)
  ) u_ecc_sram_top (
    .clk_i                 (clk),
    .rst_ni                (rst_n),
    .req_i                 (req),
    .we_i                  (we),
    .addr_i                (addr),
    .be_i                  (be),
    .wdata_i               (wdata),
    .scrub_trigger_i       (scrub_trigger),
    .test_write_mask_ni    (write_mask),
    .gnt_o                 (gnt),
    .rdata_o               (rdata),
    .err_o                 (err),
    .scrub_fix_o           (scrub_fix),
    .scrub_uncorrectable_o (scrub_uncorrectable)
  );

  always #(HalfPeriod) clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if ((cycle_limit != 0) && (cycles >= cycle_limit)) begin
      $display("Timeout: the run did not finish within %0d clock cycles", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  // Scrubber pulses are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n && scrub_fix) begin
      fix_count++;
    end
    if (rst_n && scrub_uncorrectable) begin
      uncorr_count++;
    end
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // Galois form, taps 16 14 13 11
  endfunction

  function automatic data_t rand_word();
    data_t w;
    for (int i = 0; i < DataWidth; i++) begin
      lfsr = lfsr_next(lfsr);
      w[i] = lfsr[0];
    end
    return w;
  endfunction

  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input be_t en);
    data_t m;
    m = old_w;
    for (int b = 0; b < BeWidth; b++) begin
      if (en[b]) begin
        m[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return m;
  endfunction

  function automatic void add_write(input int unsigned a, input data_t d, input be_t en,
                                    input code_t mask);
    row_t r;
    model[a]   = merge_bytes(model[a], d, en);
    r.is_write = 1'b1;
    r.addr     = a;
    r.data     = d;
    r.be       = en;
    r.mask     = mask;
    r.exp_data = '0;
    r.exp_err  = '0;
    rows.push_back(r);
  endfunction

  function automatic void add_read(input int unsigned a, input err_t exp_e);
    row_t r;
    r.is_write = 1'b0;
    r.addr     = a;
    r.data     = '0;
    r.be       = '1;
    r.mask     = '0;
    r.exp_data = model[a];
    r.exp_err  = exp_e;
    rows.push_back(r);
  endfunction

  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_err(input err_t got, input err_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int unsigned got, input int unsigned exp, input string what);
    if (got != exp) begin
      errors++;
      $display("MISMATCH at %0t: %s counted %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic close_test(input string name, input int unsigned errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: failed", name);
    end
  endtask

  task automatic apply_row(input row_t r, input string name);
    int unsigned errors_before;
    errors_before = errors;
    @(posedge clk);
    #(DriveDelay);
    req        = 1'b1;
    we         = r.is_write;
    addr       = bus_addr_t'(r.addr) << 2;
    be         = r.be;
    wdata      = r.data;
    write_mask = r.mask;  // Held until the next row, so it also covers a merge write
    do begin
      @(negedge clk);
    end while (!gnt);
    @(posedge clk);  // Accept edge
    #(DriveDelay);
    req = 1'b0;
    @(negedge clk);
    if (r.is_write) begin
      check_err(err, '0, "err_o after write");
      if (r.be != '1) begin
        check_flag(gnt, 1'b0, "gnt_o in merge cycle");
      end
    end else begin
      if (!r.exp_err[ErrMultiBit]) begin  // Data after a double error is undefined
        check_data(rdata, r.exp_data, "rdata_o");
      end
      check_err(err, r.exp_err, "err_o");
    end
    close_test(name, errors_before);
  endtask

  initial begin
    data_t       planted;
    int unsigned errors_before;
    int unsigned fix_before;
    int unsigned uncorr_before;
    clk           = 1'b0;
    rst_n         = 1'b0;
    req           = 1'b0;
    we            = 1'b0;
    addr          = '0;
    be            = '0;
    wdata         = '0;
    scrub_trigger = 1'b0;
    write_mask    = '0;
    cycles        = 0;
    errors        = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    fix_count     = 0;
    uncorr_count  = 0;
    lfsr          = 16'd74;

    for (int a = 0; a < BankSize; a++) begin
      add_write(a, rand_word(), '1, '0);
    end
    for (int a = 0; a < BankSize; a++) begin
      add_read(a, '0);
    end
    add_write(3, 32'hA5A5_5A5A, 4'b0101, '0);  // Partial writes merge with the old word
    add_read(3, '0);
    add_write(9, 32'hC3C3_3C3C, 4'b1000, '0);
    add_read(9, '0);
    // Zero data stores an all-zero codeword, so a masked bit stays 0
    planted = 32'h1234_5678;
    add_write(5, '0, '1, '0);
    add_write(5, planted, '1, code_t'(1) << 3);
    add_read(5, 2'b01);
    add_write(6, '0, '1, '0);
    add_write(6, planted, '1, (code_t'(1) << 3) | (code_t'(1) << 4));
    add_read(6, 2'b10);
    add_write(6, rand_word(), '1, '0);  // Leaves address 5 as the only faulty word
    add_read(6, '0);

    cycle_limit = 2 * (4 * (rows.size() + 1) + 4 * (BankSize + BurstLen / TrigEvery)
                       + ResetCycles);

    repeat (ResetCycles) @(posedge clk);
    #(DriveDelay);
    rst_n = 1'b1;

    foreach (rows[i]) begin
      apply_row(rows[i], $sformatf("row %0d %s addr %0d", i,
                                   rows[i].is_write ? "write" : "read", rows[i].addr));
    end

    // One full scrub walk over an idle bus
    errors_before = errors;
    fix_before    = fix_count;
    uncorr_before = uncorr_count;
    for (int s = 0; s < BankSize; s++) begin
      @(posedge clk);
      #(DriveDelay);
      scrub_trigger = 1'b1;
      @(posedge clk);
      #(DriveDelay);
      scrub_trigger = 1'b0;
      repeat (StepGap - 2) @(posedge clk);
    end
    @(negedge clk);
    check_count(fix_count - fix_before, 1, "scrub_fix_o pulses");
    check_count(uncorr_count - uncorr_before, 0, "scrub_uncorrectable_o pulses");
    close_test("scrub walk", errors_before);
    add_read(5, '0);  // Fixed in place, so no flag on the next read
    apply_row(rows[$], "read after scrub fix");

    // Back-to-back reads with triggers mixed in
    errors_before = errors;
    fix_before    = fix_count;
    uncorr_before = uncorr_count;
    for (int i = 0; i <= BurstLen; i++) begin
      @(posedge clk);
      #(DriveDelay);
      req           = (i < BurstLen);
      we            = 1'b0;
      be            = '1;
      addr          = bus_addr_t'(i % BankSize) << 2;
      scrub_trigger = (i < BurstLen) && ((i % TrigEvery) == 0);
      @(negedge clk);
      if (i < BurstLen) begin
        check_flag(gnt, 1'b1, "gnt_o during burst");
      end
      if (i > 0) begin
        check_data(rdata, model[(i - 1) % BankSize], "burst rdata_o");
        check_err(err, '0, "burst err_o");
      end
    end
    repeat (2 * StepGap) @(posedge clk);  // Lets the deferred scrub steps drain
    @(negedge clk);
    check_count(fix_count - fix_before, 0, "scrub_fix_o pulses in burst");
    check_count(uncorr_count - uncorr_before, 0, "scrub_uncorrectable_o pulses in burst");
    close_test("reads with scrubbing", errors_before);

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if ((errors == 0) && (tests_failed == 0)) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
